// File: Makefile
# Verilator build and run of the fs/4 downconverter testbench

VERILATOR ?= verilator
TOP       ?= tb_demod
FILELIST  ?= demod.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All checks passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$($(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: demod.f
+incdir+src
src/demod_pkg.sv
src/quadrant_nco.sv
src/complex_mixer.sv
src/moving_avg_lpf.sv
src/demod.sv
sim/demod_asserts.sv
sim/tb_demod.sv

// File: sim/demod_asserts.sv
`default_nettype none

module demod_asserts (
	input wire logic                     clk,
	input wire logic                     reset,
	input wire logic                     adc_rdy,
	input wire logic                     mix_rdy,
	input wire logic                     demod_rdy,
	input wire demod_pkg::nco_quadrant_t quadrant
);
	timeunit 1ns;
	timeprecision 1ns;

	int fail_count = 0;  // read by the testbench at the end

	// mixer strobe is one register behind the ADC strobe
	mix_latency: assert property (@(posedge clk) disable iff (reset)
		mix_rdy == $past(adc_rdy))
	else
	begin
		fail_count++;
		$error("mix_rdy does not follow adc_rdy by one cycle");
	end

	// output strobe two registers behind the ADC strobe
	out_latency: assert property (@(posedge clk) disable iff (reset)
		demod_rdy == $past(adc_rdy, 2))
	else
	begin
		fail_count++;
		$error("demod_rdy does not follow adc_rdy by two cycles");
	end

	// phase only moves on a strobe
	quadrant_holds: assert property (@(posedge clk) disable iff (reset)
		!adc_rdy |=> $stable(quadrant))
	else
	begin
		fail_count++;
		$error("quadrant changed without adc_rdy");
	end

	quadrant_steps: assert property (@(posedge clk) disable iff (reset)
		adc_rdy |=> (2'(quadrant) == 2'($past(quadrant)) + 2'd1))
	else
	begin
		fail_count++;
		$error("quadrant did not advance by one step after adc_rdy");
	end

	// no strobes leak out of reset
	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> (!mix_rdy && !demod_rdy))
	else
	begin
		fail_count++;
		$error("strobe high in the first cycle after reset");
	end

endmodule

bind demod demod_asserts u_asserts (
	.clk       (clk),
	.reset     (reset),
	.adc_rdy   (adc_rdy),
	.mix_rdy   (mix_rdy),
	.demod_rdy (demod_rdy),
	.quadrant  (quadrant)
);

`default_nettype wire

// File: sim/tb_demod.sv
`default_nettype none
`include "demod_params.svh"

module tb_demod;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int W        = `DEMOD_W;
	localparam int N_DC     = 12;
	localparam int DC_GAP   = 4;   // one strobe every fifth cycle
	localparam int N_TONE   = 8;
	localparam int TONE_AMP = 6;
	localparam int N_RAND   = 200;
	localparam int N_BURST  = 32;  // back-to-back strobes first
	localparam int MAX_GAP  = 3;
	localparam int N_SAT    = 24;
	// generous count of driven cycles with resets and drains
	localparam int STIM_CYCLES = 40 + N_DC * (DC_GAP + 1) + N_TONE * 6
		+ N_RAND * (MAX_GAP + 1) + N_SAT * 6;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

	localparam logic signed [W-1:0] SAMPLE_MIN = W'(-(2 ** (W - 1)));

	logic                clk = 1'b0;
	logic                reset;
	logic                adc_rdy;
	logic signed [W-1:0] i_if;
	logic signed [W-1:0] q_if;
	logic signed [W-1:0] i_bb;
	logic signed [W-1:0] q_bb;
	logic                demod_rdy;

	integer seed = 32'h2e20;
	int cycle_count  = 0;
	int value_errors = 0;
	int other_errors = 0;

	// reference model state
	int model_quadrant;
	int hist_i [3];  // [0] newest mixed sample
	int hist_q [3];

	logic signed [W-1:0] exp_i_q [$];
	logic signed [W-1:0] exp_q_q [$];
	int                  exp_cycle_q [$];  // cycle of the matching adc_rdy

	demod dut0 (
		.clk       (clk),
		.reset     (reset),
		.adc_rdy   (adc_rdy),
		.i_if      (i_if),
		.q_if      (q_if),
		.i_bb      (i_bb),
		.q_bb      (q_bb),
		.demod_rdy (demod_rdy)
	);

	always #10 clk = ~clk;

	// -16 has no positive counterpart and clips to +15
	function automatic int neg_clip(input int x);
		if (x == -(2 ** (W - 1)))
			return 2 ** (W - 1) - 1;
		return -x;
	endfunction

	// sample times (cos - j sin) at the given quadrant, one rail at a time
	function automatic int mix_rail(input int quad, input int i_in, input int q_in,
		input bit q_rail);
		case (quad)
			0:       return q_rail ? q_in : i_in;
			1:       return q_rail ? neg_clip(i_in) : q_in;
			2:       return q_rail ? neg_clip(q_in) : neg_clip(i_in);
			default: return q_rail ? i_in : neg_clip(q_in);
		endcase
	endfunction

	// mean of four samples rounded toward minus infinity
	function automatic int floor_avg(input int x0, input int x1, input int x2, input int x3);
		int s;
		s = x0 + x1 + x2 + x3;
		if (s >= 0)
			return s / 4;
		return -((-s + 3) / 4);
	endfunction

	task automatic check_value(input string name, input logic [W-1:0] actual,
		input logic [W-1:0] expected);
		if (actual !== expected)
		begin
			$display("** Error: %s is %h, expected %h", name, actual, expected);
			value_errors++;
		end
	endtask

	// model step for every accepted sample
	always @(posedge clk)
	begin
		int mi;
		int mq;
		if (reset)
		begin
			model_quadrant = 0;
			for (int k = 0; k < 3; k++)
			begin
				hist_i[k] = 0;
				hist_q[k] = 0;
			end
		end
		else if (adc_rdy)
		begin
			mi = mix_rail(model_quadrant, int'(i_if), int'(q_if), 1'b0);
			mq = mix_rail(model_quadrant, int'(i_if), int'(q_if), 1'b1);
			exp_i_q.push_back(W'(floor_avg(mi, hist_i[0], hist_i[1], hist_i[2])));
			exp_q_q.push_back(W'(floor_avg(mq, hist_q[0], hist_q[1], hist_q[2])));
			exp_cycle_q.push_back(cycle_count);
			hist_i[2] = hist_i[1];
			hist_i[1] = hist_i[0];
			hist_i[0] = mi;
			hist_q[2] = hist_q[1];
			hist_q[1] = hist_q[0];
			hist_q[0] = mq;
			model_quadrant = (model_quadrant + 1) % 4;
		end
	end

	// compare every output strobe with the oldest expected pair
	always @(posedge clk)
	begin
		int sent_at;
		if (!reset && demod_rdy)
		begin
			if (exp_i_q.size() == 0)
			begin
				$display("demod_rdy at cycle %0d with no sample in flight", cycle_count);
				other_errors++;
			end
			else
			begin
				sent_at = exp_cycle_q.pop_front();
				check_value("i_bb", i_bb, exp_i_q.pop_front());
				check_value("q_bb", q_bb, exp_q_q.pop_front());
				if (cycle_count - sent_at != 2)
				begin
					$display("demod_rdy came %0d cycles after its adc_rdy instead of 2",
						cycle_count - sent_at);
					other_errors++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("run stopped after %0d cycles, outputs never drained", cycle_count);
			$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
			$display("Checks failed");
			$finish;
		end
	end

	// one strobed sample followed by gap idle cycles
	task automatic send_sample(input logic signed [W-1:0] i_val,
		input logic signed [W-1:0] q_val, input int gap);
		i_if    <= i_val;
		q_if    <= q_val;
		adc_rdy <= 1'b1;
		@(posedge clk);
		adc_rdy <= 1'b0;  // overridden by a back-to-back sample
		repeat (gap) @(posedge clk);
	endtask

	task automatic wait_drain;
		adc_rdy <= 1'b0;
		@(posedge clk);
		while (exp_i_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic apply_reset;
		reset   <= 1'b1;
		adc_rdy <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
	endtask

	task automatic check_reset_state;
		repeat (4)
		begin
			@(posedge clk);
			check_value("demod_rdy", W'(demod_rdy), '0);
			check_value("i_bb", i_bb, '0);
			check_value("q_bb", q_bb, '0);
		end
	endtask

	task automatic run_dc_test;
		for (int n = 0; n < N_DC; n++)
			send_sample(W'(7), W'(-3), DC_GAP);
	endtask

	// +fs/4 tone lands on a constant once four samples are in the filter
	task automatic run_tone_test;
		int ti;
		int tq;
		for (int n = 0; n < N_TONE; n++)
		begin
			// I runs A 0 -A 0 and Q runs 0 A 0 -A
			ti = (n % 2 != 0) ? 0 : (n % 4 == 0) ? TONE_AMP : -TONE_AMP;
			tq = (n % 2 == 0) ? 0 : (n % 4 == 1) ? TONE_AMP : -TONE_AMP;
			send_sample(W'(ti), W'(tq), 0);
			wait_drain();
			if (n >= 3)
			begin
				check_value("i_bb", i_bb, W'(TONE_AMP));
				check_value("q_bb", q_bb, '0);
			end
		end
	endtask

	task automatic run_random_test;
		logic [31:0] r;
		int gap;
		for (int n = 0; n < N_RAND; n++)
		begin
			r   = $random(seed);
			gap = (n < N_BURST) ? 0 : int'(r[31:10]) % (MAX_GAP + 1);
			send_sample(r[4:0], r[9:5], gap);
		end
	endtask

	task automatic run_saturation_test;
		logic [31:0] r;
		for (int n = 0; n < 4; n++)
			send_sample(SAMPLE_MIN, SAMPLE_MIN, 1);
		wait_drain();
		// -16 -16 +15 +15 on each rail, floored quarter of -2
		check_value("i_bb", i_bb, W'(-1));
		check_value("q_bb", q_bb, W'(-1));
		for (int n = 4; n < N_SAT; n++)
		begin
			r = $random(seed);
			send_sample(r[0] ? SAMPLE_MIN : r[8:4], r[1] ? SAMPLE_MIN : r[13:9],
				int'(r[15:14]));
		end
	endtask

	initial
	begin
		int assert_errors;
		reset   = 1'b1;
		adc_rdy = 1'b0;
		i_if    = '0;
		q_if    = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		check_reset_state();
		run_dc_test();
		wait_drain();
		apply_reset();  // tone must start at PH_0
		run_tone_test();
		apply_reset();
		run_random_test();
		wait_drain();
		apply_reset();
		run_saturation_test();
		wait_drain();

		if (exp_i_q.size() != 0)
		begin
			$display("%0d samples were accepted but never came out", exp_i_q.size());
			other_errors++;
		end
		assert_errors = dut0.u_asserts.fail_count;
		$display("value errors: %0d, other errors: %0d, assertion failures: %0d",
			value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/complex_mixer.sv
`default_nettype none
`include "demod_params.svh"

module complex_mixer (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        adc_rdy,
	input  wire logic signed [`DEMOD_W-1:0]  i_if,
	input  wire logic signed [`DEMOD_W-1:0]  q_if,
	input  wire demod_pkg::trig_code_t       cos_code,
	input  wire demod_pkg::trig_code_t       sin_code,
	output logic signed [`DEMOD_W-1:0]       i_mix,
	output logic signed [`DEMOD_W-1:0]       q_mix,
	output logic                             mix_rdy
);
	import demod_pkg::*;

	localparam int W = `DEMOD_W;

	// extremes of a W-bit signed sample
	localparam logic signed [W-1:0] S_MIN = {1'b1, {(W-1){1'b0}}};
	localparam logic signed [W-1:0] S_MAX = {1'b0, {(W-1){1'b1}}};

	logic signed [W-1:0] i_sel;   // rail routed to the I output
	logic signed [W-1:0] q_sel;   // rail routed to the Q output
	logic                i_neg;
	logic                q_neg;

	// two's complement negate
	// -16 has no positive twin and clips to +15
	function automatic logic signed [W-1:0] sat_negate(input logic signed [W-1:0] x);
		if (x == S_MIN)
			return S_MAX;
		return -x;
	endfunction

	// multiply by +1 or -1
	function automatic logic signed [W-1:0] apply_sign(
		input logic signed [W-1:0] x,
		input logic                neg
	);
		if (neg)
			return sat_negate(x);
		return x;
	endfunction

	// (I + jQ)(cos - j sin)
	//   I out = I*cos + Q*sin
	//   Q out = Q*cos - I*sin
	// exactly one of cos and sin is nonzero, so each output is one rail
	always_comb
	begin
		if (cos_code != TRIG_ZERO)
		begin
			// PH_0 and PH_180, rails stay in place
			i_sel = i_if;
			q_sel = q_if;
			i_neg = (cos_code == TRIG_NEG);
			q_neg = (cos_code == TRIG_NEG);
		end
		else
		begin
			// PH_90 and PH_270, rails swap
			i_sel = q_if;
			q_sel = i_if;
			i_neg = (sin_code == TRIG_NEG);
			q_neg = (sin_code == TRIG_POS); // the -I*sin term
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			mix_rdy <= 1'b0;
		else
			mix_rdy <= adc_rdy;
	end

	// samples only move on a strobe and hold otherwise
	always_ff @(posedge clk)
	begin
		if (adc_rdy)
		begin
			i_mix <= apply_sign(i_sel, i_neg);
			q_mix <= apply_sign(q_sel, q_neg);
		end
	end

endmodule

`default_nettype wire

// File: src/demod.sv
`default_nettype none
`include "demod_params.svh"

// fs/4 downconverter
//   adc_rdy   -> mixer registers  -> mix_rdy
//   mix_rdy   -> filter registers -> demod_rdy
// two cycles from sample in to baseband out
module demod (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        adc_rdy,
	input  wire logic signed [`DEMOD_W-1:0]  i_if,
	input  wire logic signed [`DEMOD_W-1:0]  q_if,
	output logic signed [`DEMOD_W-1:0]       i_bb,
	output logic signed [`DEMOD_W-1:0]       q_bb,
	output logic                             demod_rdy
);
	import demod_pkg::*;

	nco_quadrant_t quadrant;   // phase used for the sample at the input now
	trig_code_t    cos_code;
	trig_code_t    sin_code;

	logic signed [`DEMOD_W-1:0] i_mix;  // rotated sample
	logic signed [`DEMOD_W-1:0] q_mix;
	logic                       mix_rdy;

	// quarter-rate local oscillator
	quadrant_nco u_nco (
		.clk      (clk),
		.reset    (reset),
		.adc_rdy  (adc_rdy),
		.quadrant (quadrant),
		.cos_code (cos_code),
		.sin_code (sin_code)
	);

	// rotation by -90 degrees per sample
	complex_mixer u_mixer (
		.clk      (clk),
		.reset    (reset),
		.adc_rdy  (adc_rdy),
		.i_if     (i_if),
		.q_if     (q_if),
		.cos_code (cos_code),
		.sin_code (sin_code),
		.i_mix    (i_mix),
		.q_mix    (q_mix),
		.mix_rdy  (mix_rdy)
	);

	// image rejection, four-tap average
	moving_avg_lpf u_lpf (
		.clk       (clk),
		.reset     (reset),
		.mix_rdy   (mix_rdy),
		.i_mix     (i_mix),
		.q_mix     (q_mix),
		.i_bb      (i_bb),
		.q_bb      (q_bb),
		.demod_rdy (demod_rdy)
	);

endmodule

`default_nettype wire

// File: src/demod_params.svh
`ifndef DEMOD_PARAMS_SVH
`define DEMOD_PARAMS_SVH

// width of every I and Q sample
// ADC inputs, mixer outputs and baseband outputs all share it
`define DEMOD_W 5

// running sum of the moving average
// four taps of DEMOD_W need two more bits
`define DEMOD_ACC_W 7

// log2 of the moving-average length
// the filter divides by this shift
`define DEMOD_TAPS_LOG2 2

`endif

// File: src/demod_pkg.sv
`default_nettype none

package demod_pkg;

	// phase of the fs/4 oscillator
	// one step of 90 degrees per ADC sample
	typedef enum logic [1:0]
	{
		PH_0   = 2'd0,
		PH_90  = 2'd1,
		PH_180 = 2'd2,
		PH_270 = 2'd3
	} nco_quadrant_t;

	// value of cosine or sine at a quadrant point
	// only 0, +1 and -1 occur at fs/4
	// encoded as a two-bit two's complement number
	typedef enum logic [1:0]
	{
		TRIG_ZERO = 2'b00, // 0
		TRIG_POS  = 2'b01, // +1
		TRIG_NEG  = 2'b11  // -1
	} trig_code_t;

	// code 2'b10 is never produced by the oscillator

	// phase    cos        sin
	// PH_0     TRIG_POS   TRIG_ZERO
	// PH_90    TRIG_ZERO  TRIG_POS
	// PH_180   TRIG_NEG   TRIG_ZERO
	// PH_270   TRIG_ZERO  TRIG_NEG

endpackage

`default_nettype wire

// File: src/moving_avg_lpf.sv
`default_nettype none
`include "demod_params.svh"

module moving_avg_lpf (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        mix_rdy,
	input  wire logic signed [`DEMOD_W-1:0]  i_mix,
	input  wire logic signed [`DEMOD_W-1:0]  q_mix,
	output logic signed [`DEMOD_W-1:0]       i_bb,
	output logic signed [`DEMOD_W-1:0]       q_bb,
	output logic                             demod_rdy
);

	localparam int W     = `DEMOD_W;
	localparam int ACC_W = `DEMOD_ACC_W;
	localparam int SHIFT = `DEMOD_TAPS_LOG2;
	localparam int TAPS  = 1 << SHIFT;
	localparam int HIST  = TAPS - 1;   // older samples kept per rail
	localparam int RAILS = 2;

	// rail 0 is I and rail 1 is Q
	logic signed [W-1:0] rail_in  [RAILS];
	logic signed [W-1:0] rail_out [RAILS];

	assign rail_in[0] = i_mix;
	assign rail_in[1] = q_mix;

	// same filter on both rails
	for (genvar r = 0; r < RAILS; r++)
	begin : g_rail
		logic signed [W-1:0]     hist [HIST];  // hist[0] newest
		logic signed [ACC_W-1:0] sum;          // sum of the samples in hist
		logic signed [ACC_W-1:0] sum_next;
		logic signed [ACC_W-1:0] new_ext;
		logic signed [ACC_W-1:0] old_ext;
		logic signed [ACC_W-1:0] quarter;
		logic signed [W-1:0]     avg_q;

		assign new_ext = ACC_W'(rail_in[r]);
		assign old_ext = ACC_W'(hist[HIST-1]);

		// the sample dropping out of the window is the oldest in history
		always_comb
		begin
			sum_next = sum + new_ext - old_ext;
			quarter  = (sum + new_ext) >>> SHIFT;  // floor of the four-tap sum / TAPS
		end

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				for (int k = 0; k < HIST; k++)
					hist[k] <= '0;
				sum   <= '0;
				avg_q <= '0;
			end
			else if (mix_rdy)
			begin
				hist[0] <= rail_in[r];
				for (int k = 1; k < HIST; k++)
					hist[k] <= hist[k-1];
				sum   <= sum_next;
				avg_q <= quarter[W-1:0];  // average of W-bit samples fits in W bits
			end
		end

		assign rail_out[r] = avg_q;
	end

	assign i_bb = rail_out[0];
	assign q_bb = rail_out[1];

	// output strobe, one cycle behind the mixer strobe
	always_ff @(posedge clk)
	begin
		if (reset)
			demod_rdy <= 1'b0;
		else
			demod_rdy <= mix_rdy;
	end

endmodule

`default_nettype wire

// File: src/quadrant_nco.sv
`default_nettype none

module quadrant_nco (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                adc_rdy,
	output demod_pkg::nco_quadrant_t quadrant,
	output demod_pkg::trig_code_t    cos_code,
	output demod_pkg::trig_code_t    sin_code
);
	import demod_pkg::*;

	nco_quadrant_t quadrant_next;

	// quarter-rate phase accumulator, wraps after PH_270
	always_comb
	begin
		case (quadrant)
			PH_0:    quadrant_next = PH_90;
			PH_90:   quadrant_next = PH_180;
			PH_180:  quadrant_next = PH_270;
			PH_270:  quadrant_next = PH_0;
			default: quadrant_next = PH_0;
		endcase
	end

	// phase moves on after the sample that used it
	always_ff @(posedge clk)
	begin
		if (reset)
			quadrant <= PH_0;
		else if (adc_rdy)
			quadrant <= quadrant_next;
	end

	// cos and sin lookup for the current phase
	always_comb
	begin
		case (quadrant)
			PH_0:
			begin
				cos_code = TRIG_POS;
				sin_code = TRIG_ZERO;
			end
			PH_90:
			begin
				cos_code = TRIG_ZERO;
				sin_code = TRIG_POS;
			end
			PH_180:
			begin
				cos_code = TRIG_NEG;
				sin_code = TRIG_ZERO;
			end
			default: // PH_270
			begin
				cos_code = TRIG_ZERO;
				sin_code = TRIG_NEG;
			end
		endcase
	end

endmodule

`default_nettype wire
